// File: run_sim.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")"

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert -Wno-fatal \
    --top-module telemetry_tb --Mdir "$BUILD_DIR" -o telemetry_sim -f sources.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/telemetry_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q 'All tests passed!' "$LOG"; then
    exit 0
else
    echo "simulation reported failures, see $LOG"
    exit 1
fi

// File: sources.f
src/telemetry_pkg.sv
src/ascii_fixed_point.sv
src/telemetry_frame.sv
src/uart_tx.sv
src/telemetry_uart_top.sv
verification/telemetry_tb_sva.sv
verification/telemetry_tb.sv

// File: src/ascii_fixed_point.sv
`timescale 1ns/1ps

module ascii_fixed_point #(
    parameter int DIGITS = 4,
    parameter int VALUE_WIDTH = 16
) (
    input  logic clk,
    input  logic reset,
    input  logic sample_valid,
    input  logic signed [VALUE_WIDTH-1:0] value,
    output logic done,
    output logic negative,
    output telemetry_pkg::byte_t [DIGITS-1:0] digits
);
    import telemetry_pkg::*;

    localparam int BCD_WIDTH = 4 * DIGITS;
    localparam int CNT_WIDTH = $clog2(VALUE_WIDTH + 1);
    localparam logic [VALUE_WIDTH-1:0] MAX_MAG = VALUE_WIDTH'(10 ** DIGITS - 1);

    logic [VALUE_WIDTH-1:0] abs_value;
    logic [VALUE_WIDTH-1:0] magnitude;
    logic [VALUE_WIDTH-1:0] shift_reg;
    logic [BCD_WIDTH-1:0] bcd;
    logic [BCD_WIDTH-1:0] bcd_adjusted;
    logic [BCD_WIDTH-1:0] bcd_next;
    logic [CNT_WIDTH-1:0] bits_left;
    logic busy;
    logic sign_captured;
    logic last_step;

    always_comb
    begin
        abs_value = value[VALUE_WIDTH-1] ? VALUE_WIDTH'(-value) : VALUE_WIDTH'(value);
        magnitude = (abs_value > MAX_MAG) ? MAX_MAG : abs_value;   // clamp to all nines
    end

    // double dabble, correct every nibble before the shift
    always_comb
    begin
        bcd_adjusted = bcd;
        for (int i = 0; i < DIGITS; i++)
        begin
            if (bcd[4*i +: 4] >= 4'd5)
                bcd_adjusted[4*i +: 4] = bcd[4*i +: 4] + 4'd3;
        end
        bcd_next = {bcd_adjusted[BCD_WIDTH-2:0], shift_reg[VALUE_WIDTH-1]};
    end

    assign last_step = busy && (bits_left == CNT_WIDTH'(1));

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            busy <= 1'b0;
            bits_left <= '0;
            done <= 1'b0;
            negative <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (sample_valid)
            begin
                busy <= 1'b1;                                   // also restarts a running one
                bits_left <= CNT_WIDTH'(VALUE_WIDTH);
            end
            else if (busy)
            begin
                bits_left <= bits_left - 1'b1;
                if (last_step)
                begin
                    busy <= 1'b0;
                    done <= 1'b1;
                    negative <= sign_captured;
                end
            end
        end
    end

    // datapath, results only change when a conversion completes
    always_ff @(posedge clk)
    begin
        if (sample_valid)
        begin
            shift_reg <= magnitude;
            bcd <= '0;
            sign_captured <= value[VALUE_WIDTH-1];
        end
        else if (busy)
        begin
            shift_reg <= shift_reg << 1;
            bcd <= bcd_next;
            if (last_step)
            begin
                for (int i = 0; i < DIGITS; i++)
                begin
                    digits[i] <= CHAR_ZERO + byte_t'(bcd_next[4*i +: 4]);
                end
            end
        end
    end

endmodule

// File: src/telemetry_frame.sv
`timescale 1ns/1ps

module telemetry_frame (
    input  logic clk,
    input  logic reset,
    input  logic start_transmission,
    input  logic data_ready,
    input  telemetry_pkg::digits4_t x_digits,
    input  telemetry_pkg::digits4_t y_digits,
    input  telemetry_pkg::digits4_t z_digits,
    input  telemetry_pkg::digits6_t t_digits,
    input  logic tx_busy,
    output logic tx_start,
    output telemetry_pkg::byte_t tx_data
);
    import telemetry_pkg::*;

    localparam addr_t LAST_ADDR = addr_t'(FRAME_LEN - 1);

    // fixed part of the message, variable positions hold a space here
    localparam byte_t TEMPLATE [FRAME_LEN] = '{
        8'h1b, 8'h5b, 8'h32, 8'h4a,                             // esc [2J
        8'h1b, 8'h5b, 8'h48,                                    // esc [H
        8'h0a, 8'h0d,
        8'h78, 8'h3a, 8'h20,                                    // "x:" and sign
        8'h20, 8'h2e, 8'h20, 8'h20, 8'h20, 8'h67,               // d.ddd g
        8'h0a, 8'h0d,
        8'h59, 8'h3a, 8'h20,
        8'h20, 8'h2e, 8'h20, 8'h20, 8'h20, 8'h67,
        8'h0a, 8'h0d,
        8'h5a, 8'h3a, 8'h20,
        8'h20, 8'h2e, 8'h20, 8'h20, 8'h20, 8'h67,
        8'h0a, 8'h0d,
        8'h54, 8'h3a, 8'h20,                                    // "T:" and sign
        8'h20, 8'h20, 8'h20, 8'h2e, 8'h20, 8'h20, 8'h20, 8'h43  // ddd.ddd C
    };

    frame_state_t state;
    frame_state_t next_state;
    addr_t addr;
    logic pending;                                              // sample arrived mid-frame
    logic seen_busy;

    digits4_t latched_x;
    digits4_t latched_y;
    digits4_t latched_z;
    digits6_t latched_t;
    digits4_t frame_x;
    digits4_t frame_y;
    digits4_t frame_z;
    digits6_t frame_t;

    function automatic byte_t sign_char(input logic is_negative);
        return is_negative ? CHAR_MINUS : CHAR_SPACE;
    endfunction

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            state <= off;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state = state;
        case (state)
            off:
                if (start_transmission)
                    next_state = wait_sample;
            wait_sample:
                if (data_ready || pending)
                    next_state = load;
            load:
                next_state = send;
            send:
                next_state = wait_busy;
            wait_busy:
                if (seen_busy && !tx_busy)
                    next_state = next_byte;
            next_byte:
                next_state = (addr == LAST_ADDR) ? wait_sample : send;
            default:
                next_state = off;
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            addr <= '0;
            pending <= 1'b0;
            seen_busy <= 1'b0;
        end
        else
        begin
            if (state == load)
                pending <= 1'b0;
            if (data_ready && state != off && state != wait_sample)
                pending <= 1'b1;                                // frame in flight, send it next

            if (state == load)
                addr <= '0;
            else if (state == next_byte && addr != LAST_ADDR)
                addr <= addr + 1'b1;

            if (state == send)
                seen_busy <= 1'b0;
            else if (state == wait_busy && tx_busy)
                seen_busy <= 1'b1;
        end
    end

    // temp done comes last, so all four results belong to one sample here
    always_ff @(posedge clk)
    begin
        if (data_ready)
        begin
            latched_x <= x_digits;
            latched_y <= y_digits;
            latched_z <= z_digits;
            latched_t <= t_digits;
        end
        if (state == load)
        begin
            frame_x <= latched_x;
            frame_y <= latched_y;
            frame_z <= latched_z;
            frame_t <= latched_t;
        end
    end

    assign tx_start = (state == send);

    always_comb
    begin
        tx_data = TEMPLATE[addr];
        case (addr)
            6'd11: tx_data = sign_char(frame_x.negative);
            6'd12: tx_data = frame_x.digit[3];
            6'd14: tx_data = frame_x.digit[2];
            6'd15: tx_data = frame_x.digit[1];
            6'd16: tx_data = frame_x.digit[0];
            6'd22: tx_data = sign_char(frame_y.negative);
            6'd23: tx_data = frame_y.digit[3];
            6'd25: tx_data = frame_y.digit[2];
            6'd26: tx_data = frame_y.digit[1];
            6'd27: tx_data = frame_y.digit[0];
            6'd33: tx_data = sign_char(frame_z.negative);
            6'd34: tx_data = frame_z.digit[3];
            6'd36: tx_data = frame_z.digit[2];
            6'd37: tx_data = frame_z.digit[1];
            6'd38: tx_data = frame_z.digit[0];
            6'd44: tx_data = sign_char(frame_t.negative);
            6'd45: tx_data = frame_t.digit[5];
            6'd46: tx_data = frame_t.digit[4];
            6'd47: tx_data = frame_t.digit[3];
            6'd49: tx_data = frame_t.digit[2];
            6'd50: tx_data = frame_t.digit[1];
            6'd51: tx_data = frame_t.digit[0];
            default: tx_data = TEMPLATE[addr];
        endcase
    end

endmodule

// File: src/telemetry_pkg.sv
package telemetry_pkg;

    typedef logic [7:0] byte_t;                // one character on the line
    typedef logic signed [15:0] accel_t;       // milli-g
    typedef logic signed [23:0] temp_t;        // milli-degrees celsius
    typedef logic [5:0] addr_t;                // byte position within a frame

    // axis result, digit[3] is the integer digit
    typedef struct packed {
        logic negative;
        byte_t [3:0] digit;
    } digits4_t;

    // temperature result, three integer and three fraction digits
    typedef struct packed {
        logic negative;
        byte_t [5:0] digit;
    } digits6_t;

    typedef enum logic [2:0] {
        off,                                   // not armed yet
        wait_sample,                           // armed, idle between frames
        load,                                  // copy latched sample into the frame
        send,                                  // pulse tx_start
        wait_busy,                             // serializer working on a byte
        next_byte
    } frame_state_t;

    localparam int FRAME_LEN = 53;

    localparam byte_t CHAR_MINUS = 8'h2d;
    localparam byte_t CHAR_SPACE = 8'h20;
    localparam byte_t CHAR_ZERO = 8'h30;       // ascii offset for bcd digits

endpackage

// File: src/telemetry_uart_top.sv
`timescale 1ns/1ps

module telemetry_uart_top #(
    parameter int CLKS_PER_BIT = 434
) (
    input  logic clk,
    input  logic reset,
    input  telemetry_pkg::accel_t accel_x,
    input  telemetry_pkg::accel_t accel_y,
    input  telemetry_pkg::accel_t accel_z,
    input  telemetry_pkg::temp_t temp,
    input  logic sample_valid,
    input  logic start_transmission,
    output logic txd
);
    import telemetry_pkg::*;

    localparam int AXIS_DIGITS = 4;
    localparam int AXIS_WIDTH = $bits(accel_t);
    localparam int TEMP_DIGITS = 6;
    localparam int TEMP_WIDTH = $bits(temp_t);

    digits4_t x_result;
    digits4_t y_result;
    digits4_t z_result;
    digits6_t t_result;
    logic data_ready;                              // temp done, the slowest converter
    logic tx_start;
    logic tx_busy;
    byte_t tx_data;

    ascii_fixed_point #(.DIGITS(AXIS_DIGITS), .VALUE_WIDTH(AXIS_WIDTH)) accel_conv_x (
        .clk(clk), .reset(reset), .sample_valid(sample_valid), .value(accel_x),
        .done(), .negative(x_result.negative), .digits(x_result.digit)
    );

    ascii_fixed_point #(.DIGITS(AXIS_DIGITS), .VALUE_WIDTH(AXIS_WIDTH)) accel_conv_y (
        .clk(clk), .reset(reset), .sample_valid(sample_valid), .value(accel_y),
        .done(), .negative(y_result.negative), .digits(y_result.digit)
    );

    ascii_fixed_point #(.DIGITS(AXIS_DIGITS), .VALUE_WIDTH(AXIS_WIDTH)) accel_conv_z (
        .clk(clk), .reset(reset), .sample_valid(sample_valid), .value(accel_z),
        .done(), .negative(z_result.negative), .digits(z_result.digit)
    );

    ascii_fixed_point #(.DIGITS(TEMP_DIGITS), .VALUE_WIDTH(TEMP_WIDTH)) temp_conv (
        .clk(clk), .reset(reset), .sample_valid(sample_valid), .value(temp),
        .done(data_ready), .negative(t_result.negative), .digits(t_result.digit)
    );

    telemetry_frame frame_seq (
        .clk(clk), .reset(reset), .start_transmission(start_transmission),
        .data_ready(data_ready),
        .x_digits(x_result), .y_digits(y_result), .z_digits(z_result), .t_digits(t_result),
        .tx_busy(tx_busy), .tx_start(tx_start), .tx_data(tx_data)
    );

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) serializer (
        .clk(clk), .reset(reset), .tx_start(tx_start), .tx_data(tx_data),
        .tx_busy(tx_busy), .txd(txd)
    );

endmodule

// File: src/uart_tx.sv
`timescale 1ns/1ps

module uart_tx #(
    parameter int CLKS_PER_BIT = 434
) (
    input  logic clk,
    input  logic reset,
    input  logic tx_start,
    input  telemetry_pkg::byte_t tx_data,
    output logic tx_busy,
    output logic txd
);
    import telemetry_pkg::*;

    localparam int BAUD_WIDTH = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
    localparam logic [3:0] STOP_BIT = 4'd9;        // 0 start, 1..8 data, 9 stop
    localparam logic [3:0] LAST_DATA = 4'd8;

    logic [BAUD_WIDTH-1:0] baud_count;
    logic [3:0] bit_index;
    byte_t shift_reg;
    logic bit_end;

    assign bit_end = (baud_count == BAUD_WIDTH'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            tx_busy <= 1'b0;
            txd <= 1'b1;                           // line idles high
            baud_count <= '0;
            bit_index <= '0;
        end
        else if (!tx_busy)
        begin
            if (tx_start)
            begin
                tx_busy <= 1'b1;
                txd <= 1'b0;                       // start bit
                baud_count <= '0;
                bit_index <= '0;
            end
        end
        else if (!bit_end)
        begin
            baud_count <= baud_count + 1'b1;
        end
        else
        begin
            baud_count <= '0;
            if (bit_index == STOP_BIT)
            begin
                tx_busy <= 1'b0;
                txd <= 1'b1;
            end
            else
            begin
                bit_index <= bit_index + 1'b1;
                txd <= (bit_index < LAST_DATA) ? shift_reg[0] : 1'b1;
            end
        end
    end

    // lsb first
    always_ff @(posedge clk)
    begin
        if (!tx_busy && tx_start)
            shift_reg <= tx_data;
        else if (tx_busy && bit_end && bit_index < LAST_DATA)
            shift_reg <= shift_reg >> 1;
    end

endmodule

// File: verification/telemetry_tb.sv
`timescale 1ns/1ps

module telemetry_tb;
    import telemetry_pkg::*;

    localparam int CLKS_PER_BIT = 8;
    localparam int CLK_PERIOD = 20;
    localparam int BYTE_CYCLES = 10 * CLKS_PER_BIT + 4;       // character plus sequencer turnaround
    localparam int FRAME_CYCLES = FRAME_LEN * BYTE_CYCLES + 64;
    localparam int START_WAIT = 2 * BYTE_CYCLES;
    localparam int IDLE_CYCLES = 3 * BYTE_CYCLES;
    localparam int WATCHDOG_CYCLES = 7 * FRAME_CYCLES;        // six full frames, one spare

    logic clk;
    logic reset;
    accel_t accel_x;
    accel_t accel_y;
    accel_t accel_z;
    temp_t temp;
    logic sample_valid;
    logic start_transmission;
    logic txd;

    byte_t expected_frame [FRAME_LEN];
    int fill_pos;
    int error_count = 0;
    int check_count = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int seed;
    int rand_x [3];
    int rand_y [3];
    int rand_z [3];
    int rand_t [3];

    telemetry_uart_top #(.CLKS_PER_BIT(CLKS_PER_BIT)) DUT (
        .clk(clk), .reset(reset), .accel_x(accel_x), .accel_y(accel_y), .accel_z(accel_z),
        .temp(temp), .sample_valid(sample_valid), .start_transmission(start_transmission),
        .txd(txd)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_byte(input string name, input byte_t actual, input byte_t expected);
        begin
            check_count++;
            if (actual !== expected)
            begin
                error_count++;
                $display("error at %0t: %s is %h, expected %h", $time, name, actual, expected);
            end
        end
    endtask

    task automatic check_line(input string name, input logic actual, input logic expected);
        begin
            check_count++;
            if (actual !== expected)
            begin
                error_count++;
                $display("error at %0t: %s is %b, expected %b", $time, name, actual, expected);
            end
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        begin
            tests_run++;
            if (error_count == errors_before)
                $display("test %s: passed", name);
            else
            begin
                tests_failed++;
                $display("test %s: %0d errors", name, error_count - errors_before);
            end
        end
    endtask

    task automatic put_char(input byte_t c);
        begin
            if (fill_pos < FRAME_LEN)
                expected_frame[fill_pos] = c;
            fill_pos++;
        end
    endtask

    task automatic put_text(input string s);
        int i;
        begin
            for (i = 0; i < s.len(); i++)
                put_char(byte_t'(s[i]));
        end
    endtask

    // sign position, then digits with the point after int_digits of them
    task automatic put_number(input int value, input int num_digits, input int int_digits);
        int magnitude;
        int limit;
        int scale;
        int pos;
        begin
            magnitude = (value < 0) ? -value : value;
            limit = 1;
            for (pos = 0; pos < num_digits; pos++)
                limit = limit * 10;
            if (magnitude > limit - 1)
                magnitude = limit - 1;                        // all nines
            put_char((value < 0) ? CHAR_MINUS : CHAR_SPACE);
            scale = limit / 10;
            for (pos = 0; pos < num_digits; pos++)
            begin
                if (pos == int_digits)
                    put_char(".");
                put_char(byte_t'(48 + (magnitude / scale) % 10));   // ascii '0' upward
                scale = scale / 10;
            end
        end
    endtask

    task automatic build_expected(input int ax, input int ay, input int az, input int t);
        begin
            fill_pos = 0;
            put_text("\033[2J\033[H\012\015");                  // clear, home, newline
            put_text("x:");
            put_number(ax, 4, 1);
            put_text("g\012\015");
            put_text("Y:");
            put_number(ay, 4, 1);
            put_text("g\012\015");
            put_text("Z:");
            put_number(az, 4, 1);
            put_text("g\012\015");
            put_text("T:");
            put_number(t, 6, 3);
            put_text("C");
            if (fill_pos != FRAME_LEN)
            begin
                error_count++;
                $display("expected frame has %0d bytes instead of %0d", fill_pos, FRAME_LEN);
            end
        end
    endtask

    task automatic drive_sample(input int ax, input int ay, input int az, input int t);
        begin
            @(posedge clk);
            #2;
            accel_x = accel_t'(ax);
            accel_y = accel_t'(ay);
            accel_z = accel_t'(az);
            temp = temp_t'(t);
            sample_valid = 1'b1;
            @(posedge clk);
            #2;
            sample_valid = 1'b0;
        end
    endtask

    task automatic watch_idle(input string name, input int cycles);
        begin
            repeat (cycles)
            begin
                @(negedge clk);
                check_line(name, txd, 1'b1);
            end
        end
    endtask

    // mid-bit sampling, counted in clocks from the first low sample
    task automatic receive_byte(output byte_t data, output bit got_byte);
        int waited;
        int bit_pos;
        begin
            data = '0;
            got_byte = 1'b0;
            waited = 0;
            @(negedge clk);
            while (txd !== 1'b0 && waited < START_WAIT)
            begin
                @(negedge clk);
                waited++;
            end
            if (txd !== 1'b0)
            begin
                error_count++;
                $display("no start bit on txd within %0d cycles at %0t", START_WAIT, $time);
            end
            else
            begin
                repeat (CLKS_PER_BIT / 2) @(negedge clk);
                check_line("start bit", txd, 1'b0);
                for (bit_pos = 0; bit_pos < 8; bit_pos++)
                begin
                    repeat (CLKS_PER_BIT) @(negedge clk);
                    data[bit_pos] = txd;                      // lsb first
                end
                repeat (CLKS_PER_BIT) @(negedge clk);
                check_line("stop bit", txd, 1'b1);
                got_byte = 1'b1;
            end
        end
    endtask

    task automatic receive_frame(input string label, input int count);
        byte_t data;
        bit got_byte;
        int i;
        begin
            for (i = 0; i < count; i++)
            begin
                receive_byte(data, got_byte);
                if (!got_byte)
                    break;
                check_byte($sformatf("%s byte %0d", label, i), data, expected_frame[i]);
            end
        end
    endtask

    task automatic test_idle_unarmed();
        int errors_before;
        begin
            errors_before = error_count;
            drive_sample(1000, -2000, 3000, 25000);
            drive_sample(-1, 1, 0, -5);
            watch_idle("txd while unarmed", IDLE_CYCLES);
            report_test("idle while unarmed", errors_before);
        end
    endtask

    task automatic test_single_frame(input string name, input int ax, input int ay,
                                     input int az, input int t);
        int errors_before;
        begin
            errors_before = error_count;
            @(posedge clk);
            #2;
            start_transmission = 1'b1;
            build_expected(ax, ay, az, t);
            drive_sample(ax, ay, az, t);
            receive_frame(name, FRAME_LEN);
            report_test(name, errors_before);
        end
    endtask

    // later samples land mid-frame, only the newest one survives
    task automatic test_back_to_back();
        int errors_before;
        int i;
        begin
            errors_before = error_count;
            for (i = 0; i < 3; i++)
            begin
                rand_x[i] = $random(seed) % 12000;
                rand_y[i] = $random(seed) % 12000;
                rand_z[i] = $random(seed) % 12000;
                rand_t[i] = $random(seed) % 1200000;
            end
            fork
                begin
                    build_expected(rand_x[0], rand_y[0], rand_z[0], rand_t[0]);
                    receive_frame("first random frame", FRAME_LEN);
                    build_expected(rand_x[2], rand_y[2], rand_z[2], rand_t[2]);
                    receive_frame("last random frame", FRAME_LEN);
                end
                begin
                    drive_sample(rand_x[0], rand_y[0], rand_z[0], rand_t[0]);
                    repeat (FRAME_CYCLES / 4) @(posedge clk);
                    drive_sample(rand_x[1], rand_y[1], rand_z[1], rand_t[1]);
                    repeat (FRAME_CYCLES / 4) @(posedge clk);
                    drive_sample(rand_x[2], rand_y[2], rand_z[2], rand_t[2]);
                end
            join
            watch_idle("txd after last random frame", IDLE_CYCLES);
            report_test("random samples back to back", errors_before);
        end
    endtask

    task automatic test_reset_mid_frame();
        int errors_before;
        int waited;
        begin
            errors_before = error_count;
            build_expected(4321, -4321, 1, 31000);
            drive_sample(4321, -4321, 1, 31000);
            receive_frame("frame before reset", 5);
            waited = 0;
            @(negedge clk);
            while (txd !== 1'b0 && waited < START_WAIT)
            begin
                @(negedge clk);
                waited++;
            end
            check_line("start bit before reset", txd, 1'b0);    // reset lands inside a character
            @(posedge clk);
            #2;
            reset = 1'b1;
            start_transmission = 1'b0;
            @(negedge clk);
            check_line("txd during reset", txd, 1'b1);
            @(posedge clk);
            #2;
            reset = 1'b0;
            drive_sample(-500, 250, 1000, 19875);
            watch_idle("txd after reset", IDLE_CYCLES);
            report_test("reset mid frame", errors_before);
            test_single_frame("frame after rearm", -500, 250, 1000, 19875);
        end
    endtask

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog: run exceeded %0d clock cycles", WATCHDOG_CYCLES);
        $display("Test failures found");
        $finish;
    end

    initial
    begin
        seed = 97;
        clk = 1'b0;
        reset = 1'b1;
        accel_x = '0;
        accel_y = '0;
        accel_z = '0;
        temp = '0;
        sample_valid = 1'b0;
        start_transmission = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;

        test_idle_unarmed();
        test_single_frame("positive readings", 1234, 567, 9, 23456);
        test_single_frame("negative readings", -1234, -8, -9999, -5);
        test_single_frame("saturated readings", 20000, -20000, -32768, 1500000);
        test_back_to_back();
        test_reset_mid_frame();

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

// File: verification/telemetry_tb_sva.sv
`timescale 1ns/1ps

module telemetry_tb_sva #(
    parameter int CLKS_PER_BIT = 434
) (
    input logic clk,
    input logic reset,
    input logic tx_start,
    input logic tx_busy,
    input logic txd
);
    localparam int BUSY_CYCLES = 10 * CLKS_PER_BIT;   // start, eight data, stop

    int busy_cycles;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            busy_cycles <= 0;
        else if (tx_busy)
            busy_cycles <= busy_cycles + 1;
        else
            busy_cycles <= 0;
    end

    idle_line_high: assert property (@(posedge clk) disable iff (reset) !tx_busy |-> txd)
        else $error("txd low while the serializer is idle");

    busy_not_too_long: assert property (@(posedge clk) disable iff (reset)
        tx_busy |-> busy_cycles < BUSY_CYCLES)
        else $error("tx_busy held longer than one character");

    busy_full_length: assert property (@(posedge clk) disable iff (reset)
        $fell(tx_busy) |-> busy_cycles == BUSY_CYCLES)
        else $error("tx_busy dropped before the stop bit ended");

    no_start_while_busy: assert property (@(posedge clk) disable iff (reset)
        tx_busy |-> !tx_start)
        else $error("tx_start raised while the serializer is busy");

endmodule

bind uart_tx telemetry_tb_sva #(.CLKS_PER_BIT(CLKS_PER_BIT)) serializer_checks (
    .clk(clk), .reset(reset), .tx_start(tx_start), .tx_busy(tx_busy), .txd(txd)
);
